// File: logic/load_pkg.sv
package load_pkg;

	// ============================
	// Download bus
	// ============================

	localparam int addr_w = 25;

	localparam logic [7:0] idx_rom     = 8'd0;
	localparam logic [7:0] idx_variant = 8'd1;
	localparam logic [7:0] idx_dip     = 8'd254;

	// One download address, read per index
	typedef union packed {
		logic [addr_w-1:0] rom;
		struct packed {
			logic [addr_w-4:0] upper;
			logic [2:0]        slot;
		} dip;
	} dl_addr_u;

	typedef struct packed {
		logic       active;
		logic       wr;
		logic [7:0] index;
		dl_addr_u   addr;
		logic [7:0] data;
	} dl_beat_t;

	// ============================
	// ROM layout and load results
	// ============================

	// 16-bit CSD and sprite ROMs start here
	localparam logic [16:0] wide_rom_base = 17'h10000;

	// 8 KB blocks of the sound board ROM
	localparam logic [11:0] snd_block_lo = 12'd7;
	localparam logic [11:0] snd_block_hi = 12'd8;

	typedef enum logic [1:0] {
		game_spyhunt = 2'd0,
		game_turbo   = 2'd1,
		game_crater  = 2'd2,
		game_none    = 2'd3
	} game_t;

	typedef struct packed {
		logic        req;
		logic [22:0] addr;
		logic [1:0]  ds;
		logic [15:0] data;
	} mem_write_t;

	typedef struct packed {
		logic        we;
		logic [13:0] addr;
		logic [7:0]  data;
	} snd_write_t;

	typedef logic [7:0][7:0] dip_bank_t;

	// Delay from reset release to the second pulse
	localparam logic [15:0] hold_cycles = 16'hFFFF;

endpackage

// File: logic/control_pkg.sv
package control_pkg;

	// ============================
	// Player controls
	// ============================

	// Bit 0 is right, bit 10 is coin
	typedef struct packed {
		logic coin;
		logic shift;
		logic fire_e;
		logic fire_d;
		logic fire_c;
		logic fire_b;
		logic fire_a;
		logic up;
		logic down;
		logic left;
		logic right;
	} player_t;

	// ============================
	// Cabinet input ports
	// ============================

	// Value of a port byte with nothing pressed
	localparam logic [7:0] port_idle = 8'hFF;

	typedef struct packed {
		logic [7:0] in0;
		logic [7:0] in1;
		logic [7:0] in2;
		logic [7:0] in3;
		logic [7:0] in4;
	} input_ports_t;

endpackage

// File: logic/hold_timer.sv
`timescale 1ns/1ps

module hold_timer (
	input  logic clk_sys,
	input  logic arst_n,
	input  logic reload,
	output logic count_at_one
);

	logic [15:0] count;

	// Down counter that parks at zero
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			count <= load_pkg::hold_cycles;
		end else if (reload) begin
			count <= load_pkg::hold_cycles;
		end else if (count != 16'd0) begin
			count <= count - 16'd1;
		end
	end

	// Terminal value, seen for one cycle only
	assign count_at_one = (count == 16'd1);

endmodule

// File: logic/reset_sequencer.sv
`timescale 1ns/1ps

module reset_sequencer (
	input  logic clk_sys,
	input  logic arst_n,
	input  logic reset_req,
	input  logic rom_download,
	output logic core_reset
);

	typedef enum logic [1:0] {
		st_wait_rom = 2'd0,
		st_hold     = 2'd1,
		st_run      = 2'd2
	} seq_state_t;

	seq_state_t state;
	seq_state_t state_nxt;
	logic       rom_download_d;
	logic       rom_done;
	logic       timer_reload;
	logic       count_at_one;

	// ============================
	// Load detection
	// ============================

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			rom_download_d <= 1'b0;
		end else begin
			rom_download_d <= rom_download;
		end
	end

	// Falling edge of the ROM download
	assign rom_done = rom_download_d && !rom_download;

	// ============================
	// Sequencer FSM
	// ============================

	always_comb begin
		state_nxt = state;
		case (state)
			st_wait_rom: if (rom_done) state_nxt = st_hold;
			st_hold:     if (!reset_req) state_nxt = st_run;
			st_run:      if (reset_req) state_nxt = st_hold;
			default:     state_nxt = st_wait_rom;
		endcase
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			state      <= st_wait_rom;
			core_reset <= 1'b1;
		end else begin
			state <= state_nxt;
			// Second pulse comes from the timer in run
			core_reset <= reset_req || (state != st_run) || count_at_one;
		end
	end

	assign timer_reload = (state != st_run) || reset_req;

	hold_timer u_hold_timer (
		.clk_sys      (clk_sys),
		.arst_n       (arst_n),
		.reload       (timer_reload),
		.count_at_one (count_at_one)
	);

endmodule

// File: logic/rom_loader.sv
`timescale 1ns/1ps

module rom_loader (
	input  logic                 clk_sys,
	input  logic                 arst_n,
	input  load_pkg::dl_beat_t   dl,
	output load_pkg::mem_write_t mem_wr,
	output load_pkg::snd_write_t snd_wr,
	output logic                 rom_download,
	output load_pkg::dip_bank_t  dips,
	output load_pkg::game_t      game
);

	logic                        wr_beat;
	logic                        rom_beat;
	logic                        dip_beat;
	logic                        variant_beat;
	logic [load_pkg::addr_w-1:0] offset;
	logic [load_pkg::addr_w-1:0] remap;
	logic [11:0]                 block;
	logic                        snd_hit;
	logic                        mem_req;
	logic [22:0]                 mem_addr;
	logic [1:0]                  mem_ds;
	logic [15:0]                 mem_data;
	logic                        snd_we;
	logic [13:0]                 snd_addr;
	logic [7:0]                  snd_data;
	logic [7:0]                  variant;

	// ============================
	// Beat decode
	// ============================

	assign wr_beat      = dl.active && dl.wr;
	assign rom_beat     = wr_beat && (dl.index == load_pkg::idx_rom);
	assign variant_beat = wr_beat && (dl.index == load_pkg::idx_variant);
	// Only slots 0 to 7 exist
	assign dip_beat     = wr_beat && (dl.index == load_pkg::idx_dip) &&
		(dl.addr.dip.upper == '0);

	assign offset = dl.addr.rom;

	// 16-bit region interleaves byte pairs using bit 14
	assign remap = (offset < load_pkg::wide_rom_base) ? offset :
		{offset[24:15], offset[13:0], offset[14]};

	assign block   = offset[24:13];
	assign snd_hit = (block == load_pkg::snd_block_lo) || (block == load_pkg::snd_block_hi);

	// ============================
	// Write ports
	// ============================

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			mem_req      <= 1'b0;
			snd_we       <= 1'b0;
			rom_download <= 1'b0;
		end else begin
			rom_download <= dl.active && (dl.index == load_pkg::idx_rom);
			snd_we       <= rom_beat && snd_hit;
			if (rom_beat) begin
				mem_req <= ~mem_req;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rom_beat) begin
			mem_addr <= remap[23:1];
			mem_ds   <= {remap[0], ~remap[0]};
			mem_data <= {dl.data, dl.data};
			snd_addr <= {~offset[13], offset[12:0]};
			snd_data <= dl.data;
		end
	end

	assign mem_wr = '{req: mem_req, addr: mem_addr, ds: mem_ds, data: mem_data};
	assign snd_wr = '{we: snd_we, addr: snd_addr, data: snd_data};

	// ============================
	// Variant and DIP registers
	// ============================

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			variant <= 8'hFF;
			dips    <= '0;
		end else begin
			if (variant_beat) begin
				variant <= dl.data;
			end
			if (dip_beat) begin
				dips[dl.addr.dip.slot] <= dl.data;
			end
		end
	end

	// Game follows the stored byte one cycle later
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			game <= load_pkg::game_none;
		end else begin
			case (variant)
				8'd0:    game <= load_pkg::game_spyhunt;
				8'd1:    game <= load_pkg::game_turbo;
				8'd2:    game <= load_pkg::game_crater;
				default: game <= load_pkg::game_none;
			endcase
		end
	end

endmodule

// File: logic/input_mapper.sv
`timescale 1ns/1ps

module input_mapper (
	input  load_pkg::game_t          game,
	input  load_pkg::dip_bank_t      dips,
	input  control_pkg::player_t     player1,
	input  control_pkg::player_t     player2,
	output control_pkg::input_ports_t ports,
	output logic                     landscape
);

	control_pkg::player_t ctl;
	logic                 service;

	// Both players share one set of cabinet inputs
	assign ctl     = player1 | player2;
	assign service = dips[1][0];

	// ============================
	// Port byte mapping
	// ============================

	always_comb begin
		landscape = 1'b0;
		ports.in0 = control_pkg::port_idle;
		ports.in1 = control_pkg::port_idle;
		ports.in2 = control_pkg::port_idle;
		ports.in3 = dips[0];
		ports.in4 = control_pkg::port_idle;

		case (game)
			load_pkg::game_spyhunt: begin
				ports.in0 = ~{service, 2'b00, ctl.shift, 3'b000, ctl.coin};
				ports.in1 = ~{3'b000, ctl.fire_a, ctl.fire_c, ctl.fire_e,
					ctl.fire_b, ctl.fire_d};
			end
			load_pkg::game_turbo: begin
				ports.in0 = ~{service, 2'b00, ctl.shift, 3'b000, ctl.coin};
				ports.in1 = ~{3'b000, ctl.fire_e, ctl.fire_d, ctl.fire_c,
					ctl.fire_b, ctl.fire_a};
			end
			load_pkg::game_crater: begin
				landscape = 1'b1;
				ports.in0 = ~{service, 2'b00, ctl.fire_a, ctl.fire_e, ctl.shift,
					1'b0, ctl.coin};
				// Spinner byte is gone, in1 stays idle
				ports.in2 = ~{1'b0, ctl.fire_b, 1'b0, ctl.fire_c, ctl.down, ctl.up,
					2'b00};
			end
			default: begin
				landscape = 1'b0;
			end
		endcase
	end

endmodule

// File: logic/cabinet_top.sv
`timescale 1ns/1ps

module cabinet_top (
	input  logic                      clk_sys,
	input  logic                      arst_n,
	input  load_pkg::dl_beat_t        dl,
	input  logic                      reset_req,
	input  control_pkg::player_t      player1,
	input  control_pkg::player_t      player2,
	output load_pkg::mem_write_t      mem_wr,
	output load_pkg::snd_write_t      snd_wr,
	output logic                      core_reset,
	output control_pkg::input_ports_t ports,
	output logic                      landscape
);

	logic                rom_download;
	load_pkg::dip_bank_t dips;
	load_pkg::game_t     game;

	// ============================
	// Loader, reset and inputs
	// ============================

	rom_loader u_rom_loader (
		.clk_sys      (clk_sys),
		.arst_n       (arst_n),
		.dl           (dl),
		.mem_wr       (mem_wr),
		.snd_wr       (snd_wr),
		.rom_download (rom_download),
		.dips         (dips),
		.game         (game)
	);

	reset_sequencer u_reset_sequencer (
		.clk_sys      (clk_sys),
		.arst_n       (arst_n),
		.reset_req    (reset_req),
		.rom_download (rom_download),
		.core_reset   (core_reset)
	);

	input_mapper u_input_mapper (
		.game      (game),
		.dips      (dips),
		.player1   (player1),
		.player2   (player2),
		.ports     (ports),
		.landscape (landscape)
	);

endmodule

// File: verification/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	output logic clk_sys,
	output logic arst_n
);

	// 4 ns period
	initial begin
		clk_sys = 1'b0;
		forever begin
			#2 clk_sys = ~clk_sys;
		end
	end

	// Reset held over the first two rising edges
	initial begin
		arst_n = 1'b0;
		repeat (2) @(posedge clk_sys);
		arst_n <= 1'b1;
	end

endmodule

// File: verification/cabinet_sva.sv
`timescale 1ns/1ps

module cabinet_sva (
	input logic                      clk_sys,
	input logic                      arst_n,
	input load_pkg::dl_beat_t        dl,
	input logic                      core_reset,
	input control_pkg::player_t      player1,
	input control_pkg::player_t      player2,
	input load_pkg::mem_write_t      mem_wr,
	input load_pkg::snd_write_t      snd_wr,
	input control_pkg::input_ports_t ports,
	input logic                      landscape
);

	int                        assert_fails = 0;
	logic                      rom_beat;
	logic                      dl_rom;
	logic                      dl_rom_q;
	logic                      loaded;
	int                        fall_age;
	int                        low_run;
	logic                      core_reset_q;
	logic                      rose;
	logic                      pulse_q;
	logic                      beat_q;
	logic                      req_prev;
	logic                      snd_hit;
	logic                      snd_q;
	logic [22:0]               exp_addr_q;
	logic [1:0]                exp_ds_q;
	logic [15:0]               exp_data_q;
	logic [13:0]               exp_snd_addr_q;
	logic [7:0]                exp_snd_data_q;
	logic [7:0]                variant_m;
	load_pkg::game_t           game_m;
	logic [7:0]                dip0_m;
	logic                      svc_m;
	control_pkg::input_ports_t exp_ports;

	// Port bytes per game with all bits active low
	function automatic control_pkg::input_ports_t expect_ports(
		input load_pkg::game_t g, input logic [7:0] dip0, input logic svc,
		input control_pkg::player_t c);
		control_pkg::input_ports_t p;
		p     = '1;
		p.in3 = dip0;
		if (g != load_pkg::game_none) begin
			p.in0[7] = ~svc;
			p.in0[0] = ~c.coin;
		end
		if (g == load_pkg::game_spyhunt) begin
			p.in0[4]   = ~c.shift;
			p.in1[4:0] = ~{c.fire_a, c.fire_c, c.fire_e, c.fire_b, c.fire_d};
		end
		if (g == load_pkg::game_turbo) begin
			p.in0[4]   = ~c.shift;
			p.in1[4:0] = ~{c.fire_e, c.fire_d, c.fire_c, c.fire_b, c.fire_a};
		end
		if (g == load_pkg::game_crater) begin
			p.in0[4] = ~c.fire_a;
			p.in0[3] = ~c.fire_e;
			p.in0[2] = ~c.shift;
			p.in2[6] = ~c.fire_b;
			p.in2[4] = ~c.fire_c;
			p.in2[3] = ~c.down;
			p.in2[2] = ~c.up;
		end
		return p;
	endfunction

	// ==============================
	// Reference model
	// ==============================

	assign rom_beat  = dl.active && dl.wr && (dl.index == load_pkg::idx_rom);
	assign dl_rom    = dl.active && (dl.index == load_pkg::idx_rom);
	assign snd_hit   = (dl.addr.rom[24:13] == load_pkg::snd_block_lo) ||
		(dl.addr.rom[24:13] == load_pkg::snd_block_hi);
	assign rose      = loaded && core_reset && !core_reset_q;
	assign exp_ports = expect_ports(game_m, dip0_m, svc_m, player1 | player2);

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			dl_rom_q     <= 1'b0;
			loaded       <= 1'b0;
			fall_age     <= 0;
			low_run      <= 0;
			core_reset_q <= 1'b1;
			pulse_q      <= 1'b0;
			beat_q       <= 1'b0;
			snd_q        <= 1'b0;
			req_prev     <= 1'b0;
		end else begin
			dl_rom_q     <= dl_rom;
			core_reset_q <= core_reset;
			pulse_q      <= rose;
			beat_q       <= rom_beat;
			snd_q        <= rom_beat && snd_hit;
			req_prev     <= mem_wr.req;
			low_run      <= core_reset ? 0 : low_run + 1;
			// End of the first download starts the release count
			if (dl_rom_q && !dl_rom && !loaded) begin
				loaded   <= 1'b1;
				fall_age <= 1;
			end else if (fall_age != 0 && fall_age < 5) begin
				fall_age <= fall_age + 1;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rom_beat) begin
			if (dl.addr.rom >= {8'd0, load_pkg::wide_rom_base}) begin
				exp_addr_q <= {dl.addr.rom[23:15], dl.addr.rom[13:0]};
				exp_ds_q   <= {dl.addr.rom[14], ~dl.addr.rom[14]};
			end else begin
				exp_addr_q <= dl.addr.rom[23:1];
				exp_ds_q   <= {dl.addr.rom[0], ~dl.addr.rom[0]};
			end
			exp_data_q     <= {dl.data, dl.data};
			exp_snd_addr_q <= {~dl.addr.rom[13], dl.addr.rom[12:0]};
			exp_snd_data_q <= dl.data;
		end
	end

	// Game follows the variant byte one cycle later
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			variant_m <= 8'hFF;
			game_m    <= load_pkg::game_none;
			dip0_m    <= 8'h00;
			svc_m     <= 1'b0;
		end else begin
			if (dl.active && dl.wr && dl.index == load_pkg::idx_variant) begin
				variant_m <= dl.data;
			end
			if (dl.active && dl.wr && dl.index == load_pkg::idx_dip &&
				dl.addr.dip.upper == '0) begin
				if (dl.addr.dip.slot == 3'd0) begin
					dip0_m <= dl.data;
				end
				if (dl.addr.dip.slot == 3'd1) begin
					svc_m <= dl.data[0];
				end
			end
			game_m <= (variant_m < 8'd3) ? load_pkg::game_t'(variant_m[1:0]) :
				load_pkg::game_none;
		end
	end

	// ==============================
	// Checks
	// ==============================

	a_hold: assert property (@(posedge clk_sys) disable iff (!arst_n)
		(!loaded || (fall_age >= 1 && fall_age <= 3)) |-> core_reset)
		else begin
			$error("[ERROR] %0t core_reset got %b expected 1", $time, $sampled(core_reset));
			assert_fails++;
		end

	a_release: assert property (@(posedge clk_sys) disable iff (!arst_n)
		(fall_age == 4) |-> !core_reset)
		else begin
			$error("[ERROR] %0t core_reset got %b expected 0", $time, $sampled(core_reset));
			assert_fails++;
		end

	a_pulse_time: assert property (@(posedge clk_sys) disable iff (!arst_n)
		rose |-> (low_run >= int'(load_pkg::hold_cycles) - 2 &&
			low_run <= int'(load_pkg::hold_cycles) + 2))
		else begin
			$error("[ERROR] %0t core_reset pulse after %0d cycles expected %0d",
				$time, $sampled(low_run), int'(load_pkg::hold_cycles));
			assert_fails++;
		end

	a_pulse_width: assert property (@(posedge clk_sys) disable iff (!arst_n)
		pulse_q |-> !core_reset)
		else begin
			$error("Second reset pulse at %0t lasted longer than one cycle", $time);
			assert_fails++;
		end

	a_mem_toggle: assert property (@(posedge clk_sys) disable iff (!arst_n)
		(mem_wr.req ^ req_prev) == beat_q)
		else begin
			$error("[ERROR] %0t mem_wr.req toggle got %b expected %b",
				$time, $sampled(mem_wr.req ^ req_prev), $sampled(beat_q));
			assert_fails++;
		end

	a_mem_word: assert property (@(posedge clk_sys) disable iff (!arst_n)
		beat_q |-> (mem_wr.addr == exp_addr_q && mem_wr.ds == exp_ds_q &&
			mem_wr.data == exp_data_q))
		else begin
			$error("[ERROR] %0t mem_wr got %h/%b/%h expected %h/%b/%h", $time,
				$sampled(mem_wr.addr), $sampled(mem_wr.ds), $sampled(mem_wr.data),
				$sampled(exp_addr_q), $sampled(exp_ds_q), $sampled(exp_data_q));
			assert_fails++;
		end

	a_snd: assert property (@(posedge clk_sys) disable iff (!arst_n)
		snd_wr.we == snd_q && (!snd_q ||
			(snd_wr.addr == exp_snd_addr_q && snd_wr.data == exp_snd_data_q)))
		else begin
			$error("[ERROR] %0t snd_wr got %b/%h/%h expected %b/%h/%h", $time,
				$sampled(snd_wr.we), $sampled(snd_wr.addr), $sampled(snd_wr.data),
				$sampled(snd_q), $sampled(exp_snd_addr_q), $sampled(exp_snd_data_q));
			assert_fails++;
		end

	a_ports: assert property (@(posedge clk_sys) disable iff (!arst_n)
		ports == exp_ports)
		else begin
			$error("[ERROR] %0t ports got %h expected %h", $time,
				$sampled(ports), $sampled(exp_ports));
			assert_fails++;
		end

	a_landscape: assert property (@(posedge clk_sys) disable iff (!arst_n)
		landscape == (game_m == load_pkg::game_crater))
		else begin
			$error("[ERROR] %0t landscape got %b expected %b", $time,
				$sampled(landscape), $sampled(game_m == load_pkg::game_crater));
			assert_fails++;
		end

endmodule

// File: verification/cabinet_tb.sv
`timescale 1ns/1ps

module cabinet_tb;

	localparam int test_cycles = 4500;
	// Hold time of the second pulse plus room for the other tests
	localparam int cycle_limit = int'(load_pkg::hold_cycles) + test_cycles;

	// Main, sound blocks 7 and 8 edges, wide region with bit 14 low and high
	localparam logic [24:0] rom_offsets [10] = '{
		25'h00000, 25'h00001, 25'h0DFFF, 25'h0E000, 25'h0FFFF,
		25'h10000, 25'h11FFF, 25'h12000, 25'h14001, 25'h1C000
	};
	localparam logic [7:0] variant_bytes [4] = '{8'd0, 8'd1, 8'd2, 8'h9C};

	logic                      clk_sys;
	logic                      arst_n;
	load_pkg::dl_beat_t        dl;
	logic                      reset_req;
	control_pkg::player_t      player1;
	control_pkg::player_t      player2;
	load_pkg::mem_write_t      mem_wr;
	load_pkg::snd_write_t      snd_wr;
	logic                      core_reset;
	control_pkg::input_ports_t ports;
	logic                      landscape;
	integer                    seed = 32'h9de1;
	int                        cycles = 0;
	int                        tests_run = 0;

	tb_clock u_tb_clock (
		.clk_sys (clk_sys),
		.arst_n  (arst_n)
	);

	cabinet_top u_cabinet_top (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.dl         (dl),
		.reset_req  (reset_req),
		.player1    (player1),
		.player2    (player2),
		.mem_wr     (mem_wr),
		.snd_wr     (snd_wr),
		.core_reset (core_reset),
		.ports      (ports),
		.landscape  (landscape)
	);

	bind cabinet_top cabinet_sva u_cabinet_sva (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.dl         (dl),
		.core_reset (core_reset),
		.player1    (player1),
		.player2    (player2),
		.mem_wr     (mem_wr),
		.snd_wr     (snd_wr),
		.ports      (ports),
		.landscape  (landscape)
	);

	task automatic send_beat(input logic [7:0] index, input logic [24:0] addr,
		input logic [7:0] data);
		load_pkg::dl_beat_t beat;
		beat          = '0;
		beat.active   = 1'b1;
		beat.wr       = 1'b1;
		beat.index    = index;
		beat.addr.rom = addr;
		beat.data     = data;
		@(posedge clk_sys);
		dl <= beat;
	endtask

	task automatic end_download();
		@(posedge clk_sys);
		dl <= '0;
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		$display("test %s finished at %0t, assertion failures so far %0d",
			name, $time, u_cabinet_top.u_cabinet_sva.assert_fails);
	endtask

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("Timeout after %0d cycles, a test or the second reset pulse never came",
				cycles);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	initial begin
		logic [31:0] r;
		int          fails;
		dl        = '0;
		reset_req = 1'b0;
		player1   = '0;
		player2   = '0;
		while (arst_n !== 1'b1) @(posedge clk_sys);

		// ==============================
		// ROM download and release
		// ==============================
		foreach (rom_offsets[i]) begin
			r = $random(seed);
			send_beat(load_pkg::idx_rom, rom_offsets[i], r[7:0]);
		end
		repeat (8) begin
			r = $random(seed);
			send_beat(load_pkg::idx_rom, {5'd0, r[19:0]}, r[31:24]);
		end
		end_download();
		while (core_reset) @(posedge clk_sys);
		finish_test("rom_download");

		send_beat(load_pkg::idx_variant, 25'd0, 8'd0);
		end_download();
		repeat (3) @(posedge clk_sys);
		finish_test("variant");

		// ==============================
		// DIP bank
		// ==============================
		r = $random(seed);
		send_beat(load_pkg::idx_dip, 25'd0, r[7:0] | 8'h01);
		send_beat(load_pkg::idx_dip, 25'd1, 8'h01);
		send_beat(load_pkg::idx_dip, 25'd3, 8'h5A);
		// Upper field set, so the bank stays as it is
		send_beat(load_pkg::idx_dip, 25'h0000008, 8'h00);
		send_beat(load_pkg::idx_dip, 25'h1000001, 8'h00);
		end_download();
		repeat (3) @(posedge clk_sys);
		finish_test("dip_bank");

		foreach (variant_bytes[v]) begin
			send_beat(load_pkg::idx_variant, 25'd0, variant_bytes[v]);
			end_download();
			repeat (24) begin
				@(posedge clk_sys);
				r = $random(seed);
				player1 <= r[10:0];
				player2 <= r[21:11];
			end
		end
		finish_test("game_ports");

		while (!core_reset) @(posedge clk_sys);
		repeat (4) @(posedge clk_sys);
		finish_test("second_reset");

		fails = u_cabinet_top.u_cabinet_sva.assert_fails;
		$display("tests run %0d, assertion failures %0d", tests_run, fails);
		if (fails == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// File: files.f
logic/load_pkg.sv
logic/control_pkg.sv
logic/hold_timer.sv
logic/reset_sequencer.sv
logic/rom_loader.sv
logic/input_mapper.sv
logic/cabinet_top.sv
verification/tb_clock.sv
verification/cabinet_sva.sv
verification/cabinet_tb.sv

// File: Makefile
BUILD := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f files.f \
		--top-module cabinet_tb -Mdir $(BUILD) -o cabinet_tb

run: compile
	./$(BUILD)/cabinet_tb +verilator+error+limit+1000 | tee sim.log
	grep -q "^STATUS: PASS$$" sim.log

clean:
	rm -rf $(BUILD) sim.log
